// ==== dv/soc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_checker (
   input wire logic clk,
   input wire logic rst_n,
   input wire soc_pkg::bus_req_t bus_req,
   input wire logic [soc_pkg::xlen-1:0] rdata,
   input wire logic timer_irq,
   input wire logic [7:0] exp_byte,
   output int checks,
   output int rdata_errs,
   output int irq_errs
);

   // RAM model, flag marks words that hold a known value
   logic [31:0] mem_m [0:soc_pkg::ram_words-1];
   bit written [0:soc_pkg::ram_words-1];
   logic [31:0] mtime_m;
   logic [31:0] mtimecmp_m;
   logic [soc_pkg::ram_aw-1:0] idx;
   soc_pkg::dev_sel_e tgt;
   logic pend = 1'b0;
   logic [31:0] exp_rdata;
   logic exp_irq;
   int n_checks = 0;
   int n_rdata_errs = 0;
   int n_irq_errs = 0;

   assign checks = n_checks;
   assign rdata_errs = n_rdata_errs;
   assign irq_errs = n_irq_errs;

   // map from the address map rules
   function automatic soc_pkg::dev_sel_e target_of(input logic [31:0] addr);
      if (addr[31:16] == soc_pkg::ram_base_hi)
         return soc_pkg::sel_ram;
      if (addr == soc_pkg::mtime_addr)
         return soc_pkg::sel_mtime;
      if (addr == soc_pkg::mtimecmp_addr)
         return soc_pkg::sel_mtimecmp;
      if (addr == soc_pkg::uart_addr)
         return soc_pkg::sel_uart;
      return soc_pkg::sel_none;
   endfunction

   // expected read result taken before the model updates at this edge
   always @(posedge clk)
   begin
      idx = bus_req.addr[12:2];
      tgt = target_of(bus_req.addr);
      if (!rst_n)
      begin
         mtime_m = '0;
         mtimecmp_m = '1;
         pend = 1'b0;
      end
      else
      begin
         pend = bus_req.re;
         if (bus_req.re)
         begin
            case (tgt)
               soc_pkg::sel_ram:
               begin
                  exp_rdata = mem_m[idx];
                  // unknown word, nothing to compare
                  pend = written[idx];
               end
               soc_pkg::sel_mtime:    exp_rdata = mtime_m;
               soc_pkg::sel_mtimecmp: exp_rdata = mtimecmp_m;
               soc_pkg::sel_uart:     exp_rdata = {24'h0, exp_byte};
               default:               exp_rdata = '0;
            endcase
         end
         if (bus_req.we && (tgt == soc_pkg::sel_ram))
         begin
            mem_m[idx] = bus_req.wdata;
            written[idx] = 1'b1;
         end
         if (bus_req.we && (tgt == soc_pkg::sel_mtimecmp))
            mtimecmp_m = bus_req.wdata;
         // counter loads on its write, else counts
         if (bus_req.we && (tgt == soc_pkg::sel_mtime))
            mtime_m = bus_req.wdata;
         else
            mtime_m = mtime_m + 1;
      end
   end

   // mid-cycle compare, outputs settled
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         exp_irq = (mtime_m >= mtimecmp_m);
         n_checks = n_checks + 1;
         if (timer_irq !== exp_irq)
         begin
            n_irq_errs = n_irq_errs + 1;
            $display("[FAIL] %0t timer_irq expected %b observed %b", $time, exp_irq, timer_irq);
         end
         if (pend)
         begin
            n_checks = n_checks + 1;
            if (rdata !== exp_rdata)
            begin
               n_rdata_errs = n_rdata_errs + 1;
               $display("[FAIL] %0t rdata expected %h observed %h", $time, exp_rdata, rdata);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

   localparam int n_ops = 400;
   localparam int n_frames = 12;
   // longest bus operation in cycles
   localparam int op_cycles = 6;
   localparam int reset_cycles = 16;
   localparam int limit_ns = (n_ops * op_cycles + reset_cycles + 200 * n_frames) * 20 * 2;

   logic clk;
   logic rst_n;
   logic rxd;
   soc_pkg::bus_req_t bus_req;
   logic [soc_pkg::xlen-1:0] rdata;
   logic timer_irq;
   logic [7:0] exp_byte;
   logic [31:0] lfsr_q;
   logic [2:0] kind;
   logic [31:0] a;
   logic [31:0] d;
   logic [7:0] data;
   logic bad;
   int checks;
   int rdata_errs;
   int irq_errs;

   soc_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus_req   (bus_req),
      .rdata     (rdata),
      .timer_irq (timer_irq),
      .rxd       (rxd)
   );

   soc_checker u_checker (
      .clk        (clk),
      .rst_n      (rst_n),
      .bus_req    (bus_req),
      .rdata      (rdata),
      .timer_irq  (timer_irq),
      .exp_byte   (exp_byte),
      .checks     (checks),
      .rdata_errs (rdata_errs),
      .irq_errs   (irq_errs)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // galois lfsr, one step per bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   // spread over the whole index range, alias bits 15:13 random
   function automatic logic [31:0] pick_ram_addr();
      logic [2:0] alias_bits;
      logic [2:0] hi;
      logic [2:0] lo;
      alias_bits = 3'(take_bits(3));
      hi = 3'(take_bits(3));
      lo = 3'(take_bits(3));
      return {16'h0000, alias_bits, hi, 5'b00000, lo, 2'b00};
   endfunction

   // text window or high unmapped space
   // low half hits the same RAM words as the RAM traffic
   function automatic logic [31:0] pick_void_addr();
      logic [31:0] ram_a;
      ram_a = pick_ram_addr();
      if (take_bits(1) != 0)
         return {soc_pkg::text_base_hi, ram_a[15:0]};
      return {1'b1, 15'(take_bits(15)), ram_a[15:0]};
   endfunction

   task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                        input logic we, input logic re);
      @(posedge clk);
      #2;
      bus_req.addr = addr;
      bus_req.wdata = wdata;
      bus_req.we = we;
      bus_req.re = re;
   endtask

   task automatic bus_idle();
      @(posedge clk);
      #2;
      bus_req = '0;
   endtask

   // 8N1, start low, lsb first, then two idle bit times
   task automatic send_frame(input logic [7:0] byte_val, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, byte_val, 1'b0};
      for (int b = 0; b < 10; b++)
      begin
         @(posedge clk);
         #2;
         rxd = bits[b];
         repeat (soc_pkg::clks_per_bit - 1) @(posedge clk);
      end
      @(posedge clk);
      #2;
      rxd = 1'b1;
      repeat (2 * soc_pkg::clks_per_bit - 1) @(posedge clk);
   endtask

   initial
   begin
      #(limit_ns);
      $display("watchdog expired, the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

   initial
   begin
      rst_n = 1'b0;
      bus_req = '0;
      rxd = 1'b1;
      exp_byte = 8'h00;
      lfsr_q = 32'h9008;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst_n = 1'b1;
      // irq stays low until mtime climbs to this
      issue(soc_pkg::mtimecmp_addr, 32'd200 + take_bits(8), 1'b1, 1'b0);
      for (int n = 0; n < n_ops; n++)
      begin
         kind = 3'(take_bits(3));
         case (kind)
            3'd0, 3'd1: issue(pick_ram_addr(), take_bits(32), 1'b1, 1'b0);
            3'd2, 3'd3: issue(pick_ram_addr(), 32'h0, 1'b0, 1'b1);
            3'd4:
            begin
               a = pick_void_addr();
               issue(a, take_bits(32), 1'b1, 1'b0);
               issue(a, 32'h0, 1'b0, 1'b1);
            end
            3'd5: issue(soc_pkg::mtime_addr, 32'h0, 1'b0, 1'b1);
            3'd6:
            begin
               d = take_bits(32);
               issue(soc_pkg::mtime_addr, d, 1'b1, 1'b0);
               issue(soc_pkg::mtimecmp_addr, d + take_bits(7), 1'b1, 1'b0);
            end
            default:
            begin
               // reads to every device back to back
               issue(pick_ram_addr(), 32'h0, 1'b0, 1'b1);
               issue(soc_pkg::mtime_addr, 32'h0, 1'b0, 1'b1);
               issue(soc_pkg::mtimecmp_addr, 32'h0, 1'b0, 1'b1);
               issue(soc_pkg::uart_addr, 32'h0, 1'b0, 1'b1);
               issue(pick_void_addr(), 32'h0, 1'b0, 1'b1);
            end
         endcase
         if (take_bits(1) != 0)
            bus_idle();
      end
      bus_idle();
      for (int f = 0; f < n_frames; f++)
      begin
         data = 8'(take_bits(8));
         // at least one framing error per run
         bad = (take_bits(3) == 0) || (f == 2);
         send_frame(data, !bad);
         #2;
         // bad stop bit keeps the old byte
         if (!bad)
            exp_byte = data;
         issue(soc_pkg::uart_addr, 32'h0, 1'b0, 1'b1);
         bus_idle();
      end
      repeat (3) @(posedge clk);
      $display("checks %0d, rdata errors %0d, timer_irq errors %0d",
               checks, rdata_errs, irq_errs);
      if ((rdata_errs + irq_errs) == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/soc_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_decode (
   input wire logic clk,
   input wire logic rst_n,
   input wire soc_pkg::bus_req_t bus_req,
   output logic ram_we,
   output logic ram_re,
   output logic mtime_we,
   output logic mtimecmp_we,
   output logic mtime_re,
   output logic mtimecmp_re,
   input wire logic [soc_pkg::xlen-1:0] ram_rdata,
   input wire logic [soc_pkg::xlen-1:0] mtime_rdata,
   input wire logic [soc_pkg::xlen-1:0] mtimecmp_rdata,
   input wire logic [7:0] rx_byte,
   output logic [soc_pkg::xlen-1:0] rdata
);

   soc_pkg::dev_sel_e sel;
   soc_pkg::dev_sel_e rd_sel_q;
   logic [7:0] uart_q;

   // address map lookup, exact matches for device registers
   always_comb
   begin
      if (bus_req.addr[31:16] == soc_pkg::ram_base_hi)
         sel = soc_pkg::sel_ram;
      else if (bus_req.addr == soc_pkg::mtime_addr)
         sel = soc_pkg::sel_mtime;
      else if (bus_req.addr == soc_pkg::mtimecmp_addr)
         sel = soc_pkg::sel_mtimecmp;
      else if (bus_req.addr == soc_pkg::uart_addr)
         sel = soc_pkg::sel_uart;
      else
         // text window and unmapped space fall here
         sel = soc_pkg::sel_none;
   end

   // per-device strobes
   assign ram_we = bus_req.we && (sel == soc_pkg::sel_ram);
   assign ram_re = bus_req.re && (sel == soc_pkg::sel_ram);
   assign mtime_we = bus_req.we && (sel == soc_pkg::sel_mtime);
   assign mtime_re = bus_req.re && (sel == soc_pkg::sel_mtime);
   assign mtimecmp_we = bus_req.we && (sel == soc_pkg::sel_mtimecmp);
   assign mtimecmp_re = bus_req.re && (sel == soc_pkg::sel_mtimecmp);

   // remember where the read in flight goes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rd_sel_q <= soc_pkg::sel_none;
      else if (bus_req.re)
         rd_sel_q <= sel;
   end

   // snapshot of the holding register so rdata holds until next read
   always_ff @(posedge clk)
   begin
      if (bus_req.re && (sel == soc_pkg::sel_uart))
         uart_q <= rx_byte;
   end

   // result mux, sources already registered on the request edge
   always_comb
   begin
      case (rd_sel_q)
         soc_pkg::sel_ram:      rdata = ram_rdata;
         soc_pkg::sel_mtime:    rdata = mtime_rdata;
         soc_pkg::sel_mtimecmp: rdata = mtimecmp_rdata;
         soc_pkg::sel_uart:     rdata = {{(soc_pkg::xlen-8){1'b0}}, uart_q};
         default:               rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   // bus data and address width
   localparam int xlen = 32;

   // data RAM geometry, word index taken from addr[12:2]
   localparam int ram_words = 2048;
   localparam int ram_aw = $clog2(ram_words);

   // upper half-word of the address picks the window
   localparam logic [15:0] ram_base_hi = 16'h0000;
   // text window stays reserved, nothing behind it
   localparam logic [15:0] text_base_hi = 16'h0001;

   // machine timer registers
   localparam logic [xlen-1:0] mtime_addr = 32'h0002_0000;
   localparam logic [xlen-1:0] mtimecmp_addr = 32'h0002_0008;

   // receive holding register
   localparam logic [xlen-1:0] uart_addr = 32'h0002_1000;

   // serial bit period in clk cycles
   localparam int clks_per_bit = 16;
   localparam int rx_cnt_w = $clog2(clks_per_bit);

   // one request from the bus master
   // at most one of we and re set per cycle
   typedef struct packed {
      logic [xlen-1:0] addr;
      logic [xlen-1:0] wdata;
      logic we;
      logic re;
   } bus_req_t;

   // target of a request after decode
   typedef enum logic [2:0] {
      sel_ram,
      sel_mtime,
      sel_mtimecmp,
      sel_uart,
      sel_none
   } dev_sel_e;

   // receiver states
   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_bits,
      rx_stop
   } rx_state_e;

endpackage

`default_nettype wire

// ==== source/soc_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_ram (
   input wire logic clk,
   input wire logic ram_we,
   input wire logic ram_re,
   input wire soc_pkg::bus_req_t bus_req,
   output logic [soc_pkg::xlen-1:0] ram_rdata
);

   // word storage, 4 bytes per entry
   logic [3:0][7:0] mem [0:soc_pkg::ram_words-1];
   logic [soc_pkg::ram_aw-1:0] idx;

   // word index, byte offset dropped
   // upper address bits ignored so the window aliases every 8 KB
   assign idx = bus_req.addr[soc_pkg::ram_aw+1:2];

   // whole-word write
   always_ff @(posedge clk)
   begin
      if (ram_we)
         mem[idx] <= bus_req.wdata;
   end

   // registered read, held until the next read strobe
   always_ff @(posedge clk)
   begin
      if (ram_re)
         ram_rdata <= mem[idx];
   end

endmodule

`default_nettype wire

// ==== source/soc_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_timer (
   input wire logic clk,
   input wire logic rst_n,
   input wire soc_pkg::bus_req_t bus_req,
   input wire logic mtime_we,
   input wire logic mtimecmp_we,
   input wire logic mtime_re,
   input wire logic mtimecmp_re,
   output logic [soc_pkg::xlen-1:0] mtime_rdata,
   output logic [soc_pkg::xlen-1:0] mtimecmp_rdata,
   output logic timer_irq
);

   logic [soc_pkg::xlen-1:0] mtime_q;
   logic [soc_pkg::xlen-1:0] mtimecmp_q;

   // free-running counter, write overrides the increment
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         mtime_q <= '0;
      else if (mtime_we)
         mtime_q <= bus_req.wdata;
      else
         mtime_q <= mtime_q + 1'b1;
   end

   // compare register
   // all ones keeps irq low after reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         mtimecmp_q <= '1;
      else if (mtimecmp_we)
         mtimecmp_q <= bus_req.wdata;
   end

   // read copies take the value from before the edge
   always_ff @(posedge clk)
   begin
      if (mtime_re)
         mtime_rdata <= mtime_q;
      if (mtimecmp_re)
         mtimecmp_rdata <= mtimecmp_q;
   end

   // level interrupt from current register values
   assign timer_irq = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// ==== source/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top (
   input wire logic clk,
   input wire logic rst_n,
   input wire soc_pkg::bus_req_t bus_req,
   output logic [soc_pkg::xlen-1:0] rdata,
   output logic timer_irq,
   input wire logic rxd
);

   // decoder strobes
   logic ram_we;
   logic ram_re;
   logic mtime_we;
   logic mtimecmp_we;
   logic mtime_re;
   logic mtimecmp_re;

   // registered read sources
   logic [soc_pkg::xlen-1:0] ram_rdata;
   logic [soc_pkg::xlen-1:0] mtime_rdata;
   logic [soc_pkg::xlen-1:0] mtimecmp_rdata;
   logic [7:0] rx_byte;

   soc_bus_decode u_decode (
      .clk            (clk),
      .rst_n          (rst_n),
      .bus_req        (bus_req),
      .ram_we         (ram_we),
      .ram_re         (ram_re),
      .mtime_we       (mtime_we),
      .mtimecmp_we    (mtimecmp_we),
      .mtime_re       (mtime_re),
      .mtimecmp_re    (mtimecmp_re),
      .ram_rdata      (ram_rdata),
      .mtime_rdata    (mtime_rdata),
      .mtimecmp_rdata (mtimecmp_rdata),
      .rx_byte        (rx_byte),
      .rdata          (rdata)
   );

   soc_ram u_ram (
      .clk       (clk),
      .ram_we    (ram_we),
      .ram_re    (ram_re),
      .bus_req   (bus_req),
      .ram_rdata (ram_rdata)
   );

   soc_timer u_timer (
      .clk            (clk),
      .rst_n          (rst_n),
      .bus_req        (bus_req),
      .mtime_we       (mtime_we),
      .mtimecmp_we    (mtimecmp_we),
      .mtime_re       (mtime_re),
      .mtimecmp_re    (mtimecmp_re),
      .mtime_rdata    (mtime_rdata),
      .mtimecmp_rdata (mtimecmp_rdata),
      .timer_irq      (timer_irq)
   );

   // serial pin straight from the package boundary
   soc_uart_rx u_uart_rx (
      .clk     (clk),
      .rst_n   (rst_n),
      .rxd     (rxd),
      .rx_byte (rx_byte)
   );

endmodule

`default_nettype wire

// ==== source/soc_uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_uart_rx (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic rxd,
   output logic [7:0] rx_byte
);

   logic rxd_m;
   logic rxd_s;
   soc_pkg::rx_state_e state_q;
   logic [soc_pkg::rx_cnt_w-1:0] cnt_q;
   logic [2:0] bit_idx_q;
   logic [7:0] shift_q;
   logic half_tick;
   logic full_tick;

   // two-flop synchronizer, idles high like the line
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rxd_m <= 1'b1;
         rxd_s <= 1'b1;
      end
      else
      begin
         rxd_m <= rxd;
         rxd_s <= rxd_m;
      end
   end

   // middle of start bit, then one full period per bit
   assign half_tick = (cnt_q == soc_pkg::rx_cnt_w'(soc_pkg::clks_per_bit / 2 - 1));
   assign full_tick = (cnt_q == soc_pkg::rx_cnt_w'(soc_pkg::clks_per_bit - 1));

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= soc_pkg::rx_idle;
         cnt_q <= '0;
         bit_idx_q <= '0;
         rx_byte <= '0;
      end
      else
      begin
         case (state_q)
            soc_pkg::rx_idle:
            begin
               cnt_q <= '0;
               // falling edge starts a frame
               if (!rxd_s)
                  state_q <= soc_pkg::rx_start;
            end
            soc_pkg::rx_start:
            begin
               if (half_tick)
               begin
                  cnt_q <= '0;
                  bit_idx_q <= '0;
                  // glitch shorter than half a bit goes back to idle
                  state_q <= rxd_s ? soc_pkg::rx_idle : soc_pkg::rx_bits;
               end
               else
                  cnt_q <= cnt_q + 1'b1;
            end
            soc_pkg::rx_bits:
            begin
               if (full_tick)
               begin
                  cnt_q <= '0;
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 3'd7)
                     state_q <= soc_pkg::rx_stop;
               end
               else
                  cnt_q <= cnt_q + 1'b1;
            end
            default:
            begin
               // stop bit, low means framing error and the byte is dropped
               if (full_tick)
               begin
                  cnt_q <= '0;
                  if (rxd_s)
                     rx_byte <= shift_q;
                  state_q <= soc_pkg::rx_idle;
               end
               else
                  cnt_q <= cnt_q + 1'b1;
            end
         endcase
      end
   end

   // data bits arrive lsb first, shift in from the top
   always_ff @(posedge clk)
   begin
      if ((state_q == soc_pkg::rx_bits) && full_tick)
         shift_q <= {rxd_s, shift_q[7:1]};
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/soc_pkg.sv
source/soc_bus_decode.sv
source/soc_ram.sv
source/soc_timer.sv
source/soc_uart_rx.sv
source/soc_top.sv
dv/soc_checker.sv
dv/tb_soc.sv
